// File: logic/core_mem_pkg.sv
`default_nettype none

package core_mem_pkg;

    // fetch channel geometry
    localparam int ICACHE_NUM_REQS   = 1;
    localparam int ICACHE_WORD_SIZE  = 4;
    localparam int ICACHE_ADDR_WIDTH = 30;
    localparam int ICACHE_TAG_WIDTH  = 8;

    // data channel geometry
    localparam int DCACHE_NUM_REQS   = 4;
    localparam int DCACHE_WORD_SIZE  = 4;
    localparam int DCACHE_ADDR_WIDTH = 30;
    localparam int DCACHE_TAG_WIDTH  = 10;

    localparam int PERF_CTR_BITS  = 32;
    localparam int PERF_ADDR_BITS = 3;

    // counter-select addresses, anything else reads zero
    localparam logic [PERF_ADDR_BITS-1:0] PERF_IFETCHES   = 3'd0;
    localparam logic [PERF_ADDR_BITS-1:0] PERF_IFETCH_LAT = 3'd1;
    localparam logic [PERF_ADDR_BITS-1:0] PERF_LOADS      = 3'd2;
    localparam logic [PERF_ADDR_BITS-1:0] PERF_STORES     = 3'd3;
    localparam logic [PERF_ADDR_BITS-1:0] PERF_LOAD_LAT   = 3'd4;

    // one lane of a fetch request
    typedef struct packed {
        logic                            rw;
        logic [ICACHE_WORD_SIZE-1:0]     byteen;
        logic [ICACHE_ADDR_WIDTH-1:0]    addr;
        logic [ICACHE_WORD_SIZE*8-1:0]   data;
        logic [ICACHE_TAG_WIDTH-1:0]     tag;
    } icache_req_t;

    typedef struct packed {
        logic [ICACHE_WORD_SIZE*8-1:0]   data;
        logic [ICACHE_TAG_WIDTH-1:0]     tag;
    } icache_rsp_t;

    // one lane of a load/store request
    typedef struct packed {
        logic                            rw;
        logic [DCACHE_WORD_SIZE-1:0]     byteen;
        logic [DCACHE_ADDR_WIDTH-1:0]    addr;
        logic [DCACHE_WORD_SIZE*8-1:0]   data;
        logic [DCACHE_TAG_WIDTH-1:0]     tag;
    } dcache_req_t;

    typedef struct packed {
        logic [DCACHE_WORD_SIZE*8-1:0]   data;
        logic [DCACHE_TAG_WIDTH-1:0]     tag;
    } dcache_rsp_t;

    typedef logic [PERF_CTR_BITS-1:0] perf_ctr_t;

    // counters kept for one cache channel
    typedef struct packed {
        perf_ctr_t reads;
        perf_ctr_t writes;
        perf_ctr_t latency;
    } mem_perf_t;

endpackage

`default_nettype wire

// File: logic/mem_traffic_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module mem_traffic_monitor #(
    parameter int NUM_REQS = 1
) (
    input  wire                    clk,
    input  wire                    reset,

    // request channel tap
    input  wire [NUM_REQS-1:0]     req_valid,
    input  wire [NUM_REQS-1:0]     req_rw,
    input  wire [NUM_REQS-1:0]     req_ready,

    // response channel tap
    input  wire [NUM_REQS-1:0]     rsp_valid,
    input  wire [NUM_REQS-1:0]     rsp_ready,

    output core_mem_pkg::mem_perf_t perf
);
    import core_mem_pkg::*;

    logic [NUM_REQS-1:0] rd_fire;
    logic [NUM_REQS-1:0] wr_fire;
    logic [NUM_REQS-1:0] rsp_fire;

    perf_ctr_t rd_count;
    perf_ctr_t wr_count;
    perf_ctr_t rsp_count;

    // reads accepted by the cache whose response has not come back yet
    perf_ctr_t pending_reads;

    mem_perf_t perf_q;

    function automatic perf_ctr_t pop_count(input logic [NUM_REQS-1:0] bits);
        perf_ctr_t n;
        n = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            n = n + perf_ctr_t'(bits[i]);
        end
        return n;
    endfunction

    assign rd_fire  = req_valid & req_ready & ~req_rw;
    assign wr_fire  = req_valid & req_ready & req_rw;
    assign rsp_fire = rsp_valid & rsp_ready;

    assign rd_count  = pop_count(rd_fire);
    assign wr_count  = pop_count(wr_fire);
    assign rsp_count = pop_count(rsp_fire);

    // a read and its response may fire in the same cycle on different lanes
    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads <= '0;
        end else begin
            pending_reads <= pending_reads + rd_count - rsp_count;
        end
    end

    // latency integrates the outstanding count held during the cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            perf_q <= '0;
        end else begin
            perf_q.reads   <= perf_q.reads + rd_count;
            perf_q.writes  <= perf_q.writes + wr_count;
            perf_q.latency <= perf_q.latency + pending_reads;
        end
    end

    assign perf = perf_q;

endmodule

`default_nettype wire

// File: logic/perf_counter_read.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counter_read (
    input  wire                                   clk,
    input  wire                                   reset,

    input  wire core_mem_pkg::mem_perf_t          icache_perf,
    input  wire core_mem_pkg::mem_perf_t          dcache_perf,

    // read request
    input  wire                                   perf_rd_valid,
    input  wire [core_mem_pkg::PERF_ADDR_BITS-1:0] perf_rd_addr,
    output logic                                  perf_rd_ready,

    // read response
    output logic                                  perf_rsp_valid,
    output core_mem_pkg::perf_ctr_t               perf_rsp_data,
    input  wire                                   perf_rsp_ready
);
    import core_mem_pkg::*;

    logic      rd_fire;
    perf_ctr_t sel_data;

    // one-entry response slot, refilled in the cycle it drains
    assign perf_rd_ready = ~perf_rsp_valid | perf_rsp_ready;
    assign rd_fire       = perf_rd_valid & perf_rd_ready;

    // fetch never writes so the ifetch count is the icache read count
    always_comb begin
        case (perf_rd_addr)
            PERF_IFETCHES:   sel_data = icache_perf.reads;
            PERF_IFETCH_LAT: sel_data = icache_perf.latency;
            PERF_LOADS:      sel_data = dcache_perf.reads;
            PERF_STORES:     sel_data = dcache_perf.writes;
            PERF_LOAD_LAT:   sel_data = dcache_perf.latency;
            default:         sel_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            perf_rsp_valid <= 1'b0;
        end else if (rd_fire) begin
            perf_rsp_valid <= 1'b1;
        end else if (perf_rsp_ready) begin
            perf_rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            perf_rsp_data <= sel_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_mem_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_monitor (
    input  wire clk,
    input  wire reset,

    // fetch requests, core side in, cache side out
    input  wire [core_mem_pkg::ICACHE_NUM_REQS-1:0]                         icache_req_in_valid,
    input  wire core_mem_pkg::icache_req_t [core_mem_pkg::ICACHE_NUM_REQS-1:0] icache_req_in,
    output logic [core_mem_pkg::ICACHE_NUM_REQS-1:0]                        icache_req_in_ready,
    output logic [core_mem_pkg::ICACHE_NUM_REQS-1:0]                        icache_req_out_valid,
    output core_mem_pkg::icache_req_t [core_mem_pkg::ICACHE_NUM_REQS-1:0]   icache_req_out,
    input  wire [core_mem_pkg::ICACHE_NUM_REQS-1:0]                         icache_req_out_ready,

    // fetch responses, cache side in, core side out
    input  wire [core_mem_pkg::ICACHE_NUM_REQS-1:0]                         icache_rsp_in_valid,
    input  wire core_mem_pkg::icache_rsp_t [core_mem_pkg::ICACHE_NUM_REQS-1:0] icache_rsp_in,
    output logic [core_mem_pkg::ICACHE_NUM_REQS-1:0]                        icache_rsp_in_ready,
    output logic [core_mem_pkg::ICACHE_NUM_REQS-1:0]                        icache_rsp_out_valid,
    output core_mem_pkg::icache_rsp_t [core_mem_pkg::ICACHE_NUM_REQS-1:0]   icache_rsp_out,
    input  wire [core_mem_pkg::ICACHE_NUM_REQS-1:0]                         icache_rsp_out_ready,

    // load/store requests
    input  wire [core_mem_pkg::DCACHE_NUM_REQS-1:0]                         dcache_req_in_valid,
    input  wire core_mem_pkg::dcache_req_t [core_mem_pkg::DCACHE_NUM_REQS-1:0] dcache_req_in,
    output logic [core_mem_pkg::DCACHE_NUM_REQS-1:0]                        dcache_req_in_ready,
    output logic [core_mem_pkg::DCACHE_NUM_REQS-1:0]                        dcache_req_out_valid,
    output core_mem_pkg::dcache_req_t [core_mem_pkg::DCACHE_NUM_REQS-1:0]   dcache_req_out,
    input  wire [core_mem_pkg::DCACHE_NUM_REQS-1:0]                         dcache_req_out_ready,

    // load/store responses
    input  wire [core_mem_pkg::DCACHE_NUM_REQS-1:0]                         dcache_rsp_in_valid,
    input  wire core_mem_pkg::dcache_rsp_t [core_mem_pkg::DCACHE_NUM_REQS-1:0] dcache_rsp_in,
    output logic [core_mem_pkg::DCACHE_NUM_REQS-1:0]                        dcache_rsp_in_ready,
    output logic [core_mem_pkg::DCACHE_NUM_REQS-1:0]                        dcache_rsp_out_valid,
    output core_mem_pkg::dcache_rsp_t [core_mem_pkg::DCACHE_NUM_REQS-1:0]   dcache_rsp_out,
    input  wire [core_mem_pkg::DCACHE_NUM_REQS-1:0]                         dcache_rsp_out_ready,

    // counter-read port
    input  wire                                    perf_rd_valid,
    input  wire [core_mem_pkg::PERF_ADDR_BITS-1:0] perf_rd_addr,
    output logic                                   perf_rd_ready,
    output logic                                   perf_rsp_valid,
    output core_mem_pkg::perf_ctr_t                perf_rsp_data,
    input  wire                                    perf_rsp_ready
);
    import core_mem_pkg::*;

    logic [ICACHE_NUM_REQS-1:0] icache_req_rw;
    logic [DCACHE_NUM_REQS-1:0] dcache_req_rw;

    mem_perf_t icache_perf;
    mem_perf_t dcache_perf;

    // both channels pass straight through
    assign icache_req_out_valid = icache_req_in_valid;
    assign icache_req_out       = icache_req_in;
    assign icache_req_in_ready  = icache_req_out_ready;
    assign icache_rsp_out_valid = icache_rsp_in_valid;
    assign icache_rsp_out       = icache_rsp_in;
    assign icache_rsp_in_ready  = icache_rsp_out_ready;

    assign dcache_req_out_valid = dcache_req_in_valid;
    assign dcache_req_out       = dcache_req_in;
    assign dcache_req_in_ready  = dcache_req_out_ready;
    assign dcache_rsp_out_valid = dcache_rsp_in_valid;
    assign dcache_rsp_out       = dcache_rsp_in;
    assign dcache_rsp_in_ready  = dcache_rsp_out_ready;

    // gather the per-lane rw bits out of the request structs
    always_comb begin
        for (int i = 0; i < ICACHE_NUM_REQS; i++) begin
            icache_req_rw[i] = icache_req_in[i].rw;
        end
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            dcache_req_rw[i] = dcache_req_in[i].rw;
        end
    end

    mem_traffic_monitor #(
        .NUM_REQS (ICACHE_NUM_REQS)
    ) u_icache_perf (
        .clk       (clk),
        .reset     (reset),
        .req_valid (icache_req_in_valid),
        .req_rw    (icache_req_rw),
        .req_ready (icache_req_out_ready),
        .rsp_valid (icache_rsp_in_valid),
        .rsp_ready (icache_rsp_out_ready),
        .perf      (icache_perf)
    );

    mem_traffic_monitor #(
        .NUM_REQS (DCACHE_NUM_REQS)
    ) u_dcache_perf (
        .clk       (clk),
        .reset     (reset),
        .req_valid (dcache_req_in_valid),
        .req_rw    (dcache_req_rw),
        .req_ready (dcache_req_out_ready),
        .rsp_valid (dcache_rsp_in_valid),
        .rsp_ready (dcache_rsp_out_ready),
        .perf      (dcache_perf)
    );

    perf_counter_read u_perf_read (
        .clk            (clk),
        .reset          (reset),
        .icache_perf    (icache_perf),
        .dcache_perf    (dcache_perf),
        .perf_rd_valid  (perf_rd_valid),
        .perf_rd_addr   (perf_rd_addr),
        .perf_rd_ready  (perf_rd_ready),
        .perf_rsp_valid (perf_rsp_valid),
        .perf_rsp_data  (perf_rsp_data),
        .perf_rsp_ready (perf_rsp_ready)
    );

endmodule

`default_nettype wire

// File: test/core_mem_monitor_props.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_monitor_props (
    input wire                                   clk,
    input wire                                   reset,
    input wire [core_mem_pkg::DCACHE_NUM_REQS-1:0] req_valid,
    input wire [core_mem_pkg::DCACHE_NUM_REQS-1:0] req_ready,
    input wire [core_mem_pkg::DCACHE_NUM_REQS-1:0] req_rw,
    input wire core_mem_pkg::dcache_req_t [core_mem_pkg::DCACHE_NUM_REQS-1:0] req,
    input wire [core_mem_pkg::DCACHE_NUM_REQS-1:0] rsp_valid,
    input wire [core_mem_pkg::DCACHE_NUM_REQS-1:0] rsp_ready,
    input wire                                   perf_rd_valid,
    input wire                                   perf_rd_ready,
    input wire                                   perf_rsp_valid,
    input wire core_mem_pkg::perf_ctr_t          perf_rsp_data,
    input wire                                   perf_rsp_ready
);
    import core_mem_pkg::*;

    logic [31:0] pend;

    // outstanding load count seen at the ports
    always_ff @(posedge clk) begin
        if (reset) begin
            pend <= '0;
        end else begin
            pend <= pend + $countones(req_valid & req_ready & ~req_rw)
                    - $countones(rsp_valid & rsp_ready);
        end
    end

    rsp_held: assert property (@(posedge clk) disable iff (reset)
        perf_rsp_valid && !perf_rsp_ready |=> perf_rsp_valid && $stable(perf_rsp_data))
        else $error("perf response changed while stalled");

    // an accepted read always leaves a response in the slot
    rd_accept_rsp: assert property (@(posedge clk) disable iff (reset)
        perf_rd_valid && perf_rd_ready |=> perf_rsp_valid)
        else $error("no perf response after an accepted read");

    rsp_after_load: assert property (@(posedge clk) disable iff (reset)
        $countones(rsp_valid & rsp_ready) <= pend)
        else $error("dcache response fired without a pending load");

    for (genvar i = 0; i < DCACHE_NUM_REQS; i++) begin : g_lane
        req_stable: assert property (@(posedge clk) disable iff (reset)
            req_valid[i] && !req_ready[i] |=> req_valid[i] && $stable(req[i]))
            else $error("dcache request lane dropped while stalled");
    end

endmodule

`default_nettype wire

// File: test/core_mem_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_mem_monitor_tb;
    import core_mem_pkg::*;

    localparam int TIMEOUT = 40;

    logic clk;
    logic reset;
    logic [ICACHE_NUM_REQS-1:0] icache_req_in_valid;
    icache_req_t [ICACHE_NUM_REQS-1:0] icache_req_in;
    logic [ICACHE_NUM_REQS-1:0] icache_req_in_ready;
    logic [ICACHE_NUM_REQS-1:0] icache_req_out_valid;
    icache_req_t [ICACHE_NUM_REQS-1:0] icache_req_out;
    logic [ICACHE_NUM_REQS-1:0] icache_req_out_ready;
    logic [ICACHE_NUM_REQS-1:0] icache_rsp_in_valid;
    icache_rsp_t [ICACHE_NUM_REQS-1:0] icache_rsp_in;
    logic [ICACHE_NUM_REQS-1:0] icache_rsp_in_ready;
    logic [ICACHE_NUM_REQS-1:0] icache_rsp_out_valid;
    icache_rsp_t [ICACHE_NUM_REQS-1:0] icache_rsp_out;
    logic [ICACHE_NUM_REQS-1:0] icache_rsp_out_ready;
    logic [DCACHE_NUM_REQS-1:0] dcache_req_in_valid;
    dcache_req_t [DCACHE_NUM_REQS-1:0] dcache_req_in;
    logic [DCACHE_NUM_REQS-1:0] dcache_req_in_ready;
    logic [DCACHE_NUM_REQS-1:0] dcache_req_out_valid;
    dcache_req_t [DCACHE_NUM_REQS-1:0] dcache_req_out;
    logic [DCACHE_NUM_REQS-1:0] dcache_req_out_ready;
    logic [DCACHE_NUM_REQS-1:0] dcache_rsp_in_valid;
    dcache_rsp_t [DCACHE_NUM_REQS-1:0] dcache_rsp_in;
    logic [DCACHE_NUM_REQS-1:0] dcache_rsp_in_ready;
    logic [DCACHE_NUM_REQS-1:0] dcache_rsp_out_valid;
    dcache_rsp_t [DCACHE_NUM_REQS-1:0] dcache_rsp_out;
    logic [DCACHE_NUM_REQS-1:0] dcache_rsp_out_ready;
    logic perf_rd_valid;
    logic [PERF_ADDR_BITS-1:0] perf_rd_addr;
    logic perf_rd_ready;
    logic perf_rsp_valid;
    perf_ctr_t perf_rsp_data;
    logic perf_rsp_ready;

    int seed;
    bit traffic_on;
    bit reset_req;
    bit rd_req;
    bit rsp_take;
    bit rd_fired;
    logic [PERF_ADDR_BITS-1:0] rd_addr_req;
    perf_ctr_t rd_expect;

    // reference counters rebuilt from port fires
    perf_ctr_t ic_pend;
    perf_ctr_t ic_reads;
    perf_ctr_t ic_lat;
    perf_ctr_t dc_pend;
    perf_ctr_t dc_reads;
    perf_ctr_t dc_writes;
    perf_ctr_t dc_lat;

    core_mem_monitor u_core_mem_monitor (.*);

    bind core_mem_monitor core_mem_monitor_props u_props (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (dcache_req_in_valid),
        .req_ready      (dcache_req_out_ready),
        .req_rw         (dcache_req_rw),
        .req            (dcache_req_in),
        .rsp_valid      (dcache_rsp_in_valid),
        .rsp_ready      (dcache_rsp_out_ready),
        .perf_rd_valid  (perf_rd_valid),
        .perf_rd_ready  (perf_rd_ready),
        .perf_rsp_valid (perf_rsp_valid),
        .perf_rsp_data  (perf_rsp_data),
        .perf_rsp_ready (perf_rsp_ready)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_icache_req(input string name, input icache_req_t got,
                                    input icache_req_t exp);
        if (got !== exp) fail($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_icache_rsp(input string name, input icache_rsp_t got,
                                    input icache_rsp_t exp);
        if (got !== exp) fail($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_dcache_req(input string name, input dcache_req_t got,
                                    input dcache_req_t exp);
        if (got !== exp) fail($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_dcache_rsp(input string name, input dcache_rsp_t got,
                                    input dcache_rsp_t exp);
        if (got !== exp) fail($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_counter(input string name, input perf_ctr_t got, input perf_ctr_t exp);
        if (got !== exp) fail($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flags(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) fail($sformatf("[ERROR] %s: got %h expected %h", name, got, exp));
    endtask

    function automatic perf_ctr_t model_value(input logic [PERF_ADDR_BITS-1:0] addr);
        case (addr)
            3'd0:    return ic_reads;
            3'd1:    return ic_lat;
            3'd2:    return dc_reads;
            3'd3:    return dc_writes;
            3'd4:    return dc_lat;
            default: return '0;
        endcase
    endfunction

    // stalled lanes keep valid and payload, responses never outrun pending reads
    task automatic drive_traffic();
        int r;
        int offered;
        logic [95:0] bits;
        for (int i = 0; i < ICACHE_NUM_REQS; i++) begin
            r = $random(seed);
            bits = {$random(seed), $random(seed), $random(seed)};
            if (!(icache_req_in_valid[i] && !icache_req_out_ready[i])) begin
                icache_req_in_valid[i] = traffic_on && r[0];
                icache_req_in[i] = bits[$bits(icache_req_t)-1:0];
                icache_req_in[i].rw = 1'b0;
            end
            icache_req_out_ready[i] = r[1] | r[2];
            if (!(icache_rsp_in_valid[i] && !icache_rsp_out_ready[i])) begin
                icache_rsp_in_valid[i] = traffic_on && r[5] && (perf_ctr_t'(i) < ic_pend);
                icache_rsp_in[i] = bits[95 -: $bits(icache_rsp_t)];
            end
            icache_rsp_out_ready[i] = r[3] | r[4];
        end
        offered = 0;
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            if (dcache_rsp_in_valid[i] && !dcache_rsp_out_ready[i]) offered++;
        end
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            r = $random(seed);
            bits = {$random(seed), $random(seed), $random(seed)};
            if (!(dcache_req_in_valid[i] && !dcache_req_out_ready[i])) begin
                dcache_req_in_valid[i] = traffic_on && r[0];
                dcache_req_in[i] = bits[$bits(dcache_req_t)-1:0];
                dcache_req_in[i].rw = r[6] & r[7];
            end
            dcache_req_out_ready[i] = r[1] | r[2];
            if (!(dcache_rsp_in_valid[i] && !dcache_rsp_out_ready[i])) begin
                dcache_rsp_in_valid[i] = traffic_on && r[5] && (perf_ctr_t'(offered) < dc_pend);
                if (dcache_rsp_in_valid[i]) offered++;
                dcache_rsp_in[i] = bits[95 -: $bits(dcache_rsp_t)];
            end
            dcache_rsp_out_ready[i] = r[3] | r[4];
        end
    endtask

    task automatic sample_cycle();
        int ic_rd;
        int dc_rd;
        int dc_wr;
        check_flags("icache_req_out_valid", 32'(icache_req_out_valid), 32'(icache_req_in_valid));
        check_flags("icache_req_in_ready", 32'(icache_req_in_ready), 32'(icache_req_out_ready));
        check_flags("icache_rsp_out_valid", 32'(icache_rsp_out_valid), 32'(icache_rsp_in_valid));
        check_flags("icache_rsp_in_ready", 32'(icache_rsp_in_ready), 32'(icache_rsp_out_ready));
        check_icache_req("icache_req_out", icache_req_out[0], icache_req_in[0]);
        check_icache_rsp("icache_rsp_out", icache_rsp_out[0], icache_rsp_in[0]);
        check_flags("dcache_req_out_valid", 32'(dcache_req_out_valid), 32'(dcache_req_in_valid));
        check_flags("dcache_req_in_ready", 32'(dcache_req_in_ready), 32'(dcache_req_out_ready));
        check_flags("dcache_rsp_out_valid", 32'(dcache_rsp_out_valid), 32'(dcache_rsp_in_valid));
        check_flags("dcache_rsp_in_ready", 32'(dcache_rsp_in_ready), 32'(dcache_rsp_out_ready));
        for (int i = 0; i < DCACHE_NUM_REQS; i++) begin
            check_dcache_req($sformatf("dcache_req_out[%0d]", i), dcache_req_out[i],
                             dcache_req_in[i]);
            check_dcache_rsp($sformatf("dcache_rsp_out[%0d]", i), dcache_rsp_out[i],
                             dcache_rsp_in[i]);
        end
        if (!reset) begin
            // capture uses the counts as they stand during the accepting cycle
            if (perf_rd_valid && perf_rd_ready) begin
                rd_fired = 1'b1;
                rd_expect = model_value(perf_rd_addr);
            end
            ic_rd = $countones(icache_req_in_valid & icache_req_out_ready);
            dc_rd = $countones(dcache_req_in_valid & dcache_req_out_ready & ~dcache_req_rw());
            dc_wr = $countones(dcache_req_in_valid & dcache_req_out_ready & dcache_req_rw());
            ic_lat = ic_lat + ic_pend;
            dc_lat = dc_lat + dc_pend;
            ic_pend = ic_pend + perf_ctr_t'(ic_rd)
                      - perf_ctr_t'($countones(icache_rsp_in_valid & icache_rsp_out_ready));
            dc_pend = dc_pend + perf_ctr_t'(dc_rd)
                      - perf_ctr_t'($countones(dcache_rsp_in_valid & dcache_rsp_out_ready));
            ic_reads = ic_reads + perf_ctr_t'(ic_rd);
            dc_reads = dc_reads + perf_ctr_t'(dc_rd);
            dc_writes = dc_writes + perf_ctr_t'(dc_wr);
        end
    endtask

    function automatic logic [DCACHE_NUM_REQS-1:0] dcache_req_rw();
        logic [DCACHE_NUM_REQS-1:0] v;
        for (int i = 0; i < DCACHE_NUM_REQS; i++) v[i] = dcache_req_in[i].rw;
        return v;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        reset = reset_req;
        perf_rd_valid = rd_req;
        perf_rd_addr = rd_addr_req;
        perf_rsp_ready = rsp_take;
        drive_traffic();
        #2;
        sample_cycle();
    endtask

    task automatic read_and_check(input logic [PERF_ADDR_BITS-1:0] addr, input int hold);
        int n;
        rd_req = 1'b1;
        rd_addr_req = addr;
        rsp_take = 1'b0;
        rd_fired = 1'b0;
        n = 0;
        while (!rd_fired) begin
            step();
            n++;
            if (n > TIMEOUT) fail("counter read request was never accepted");
        end
        rd_req = 1'b0;
        n = 0;
        do begin
            step();
            n++;
            if (n > TIMEOUT) fail("counter read response never arrived");
        end while (!perf_rsp_valid);
        for (int h = 0; h < hold; h++) begin
            check_counter($sformatf("perf_rsp_data[%0d]", addr), perf_rsp_data, rd_expect);
            step();
            check_flags("perf_rsp_valid", 32'(perf_rsp_valid), 32'd1);
        end
        rsp_take = 1'b1;
        step();
        check_counter($sformatf("perf_rsp_data[%0d]", addr), perf_rsp_data, rd_expect);
        rsp_take = 1'b0;
    endtask

    initial begin
        seed = 32'hbe;
        reset = 1'b1;
        icache_req_in_valid = '0;
        icache_req_in = '0;
        icache_req_out_ready = '0;
        icache_rsp_in_valid = '0;
        icache_rsp_in = '0;
        icache_rsp_out_ready = '0;
        dcache_req_in_valid = '0;
        dcache_req_in = '0;
        dcache_req_out_ready = '0;
        dcache_rsp_in_valid = '0;
        dcache_rsp_in = '0;
        dcache_rsp_out_ready = '0;
        perf_rd_valid = 1'b0;
        perf_rd_addr = '0;
        perf_rsp_ready = 1'b0;
        {ic_pend, ic_reads, ic_lat} = '0;
        {dc_pend, dc_reads, dc_writes, dc_lat} = '0;
        traffic_on = 1'b0;
        reset_req = 1'b1;
        rd_req = 1'b0;
        rsp_take = 1'b0;
        rd_addr_req = '0;
        repeat (7) step();
        reset_req = 1'b0;
        step();
        check_flags("perf_rsp_valid", 32'(perf_rsp_valid), 32'd0);
        check_flags("perf_rd_ready", 32'(perf_rd_ready), 32'd1);
        // counters are idle right after reset
        for (int a = 0; a < 5; a++) begin
            read_and_check(PERF_ADDR_BITS'(a), 0);
            check_counter("reset counter", perf_rsp_data, '0);
        end
        traffic_on = 1'b1;
        for (int k = 0; k < 80; k++) begin
            repeat (($random(seed) & 7) + 1) step();
            read_and_check(PERF_ADDR_BITS'($random(seed)), $random(seed) & 3);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
logic/core_mem_pkg.sv
logic/mem_traffic_monitor.sv
logic/perf_counter_read.sv
logic/core_mem_monitor.sv
test/core_mem_monitor_props.sv
test/core_mem_monitor_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f \
		--top-module core_mem_monitor_tb -Mdir obj_dir
	./obj_dir/Vcore_mem_monitor_tb

clean:
	rm -rf obj_dir
